// ==== logic/capture_pkg.sv ====
package capture_pkg;

	parameter int chan_w = 16;	// one acquisition channel
	parameter int chans = 3;	// channels packed per sample
	parameter int sample_w = chans * chan_w;	// 48 bits
	parameter int word_w = 32;	// downstream bus word

	// channel 0 occupies the lowest chan_w bits
	typedef logic [sample_w-1:0] sample_t;

	typedef logic [chan_w-1:0] chan_t;

	typedef logic [word_w-1:0] word_t;

	typedef logic [1:0] lane_t;	// channel index, 0 to 2

	// idle waits for a buffered sample, laneN shows channel N
	typedef enum logic [1:0] {
		idle,
		lane0,
		lane1,
		lane2
	} split_state_t;

endpackage

// ==== logic/chan_word_if.sv ====
`timescale 1ns/1ps

interface chan_word_if;

	logic                valid;
	logic                ready;
	capture_pkg::word_t  data;	// zero-extended channel value
	capture_pkg::lane_t  lane;	// which channel data came from

	// splitter side
	modport src (
		output valid,
		output data,
		output lane,
		input  ready
	);

	// framer side
	modport dst (
		input  valid,
		input  data,
		input  lane,
		output ready
	);

endinterface

// ==== logic/sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer #(
	parameter int depth = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  capture_pkg::sample_t  in_sample,

	output logic                  buf_valid,
	input  logic                  buf_ready,
	output capture_pkg::sample_t  buf_sample,

	output logic                  overflow
);

	localparam int addr_w = $clog2(depth);

	// sample storage
	capture_pkg::sample_t mem [depth];

	// one extra bit tells full from empty
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;

	logic full;
	logic empty;
	logic wr_en;
	logic rd_en;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
		(wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

	assign in_ready = !full;
	assign buf_valid = !empty;

	assign wr_en = in_valid && in_ready;
	assign rd_en = buf_valid && buf_ready;

	// head of queue straight from storage
	assign buf_sample = mem[rd_ptr[addr_w-1:0]];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[addr_w-1:0]] <= in_sample;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (rd_en) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// sample offered while full is lost; flag sticks until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (in_valid && full) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== logic/sample_splitter.sv ====
`timescale 1ns/1ps

module sample_splitter (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  buf_valid,
	output logic                  buf_ready,
	input  capture_pkg::sample_t  buf_sample,

	chan_word_if.src              words
);

	capture_pkg::split_state_t state;
	capture_pkg::split_state_t state_nx;

	capture_pkg::sample_t sample_q;	// sample being split
	capture_pkg::lane_t   lane;
	capture_pkg::chan_t   chan;

	logic load;
	logic step;

	assign step = words.valid && words.ready;

	// reload on the last word's edge keeps words back to back
	assign buf_ready = (state == capture_pkg::idle) ||
		((state == capture_pkg::lane2) && words.ready);
	assign load = buf_valid && buf_ready;

	always_comb begin
		case (state)
			capture_pkg::lane1: begin
				lane = 2'd1;
			end
			capture_pkg::lane2: begin
				lane = 2'd2;
			end
			default: begin
				lane = 2'd0;
			end
		endcase
	end

	assign chan = sample_q[int'(lane) * capture_pkg::chan_w +: capture_pkg::chan_w];

	assign words.valid = (state != capture_pkg::idle);
	assign words.lane = lane;
	assign words.data = {{(capture_pkg::word_w - capture_pkg::chan_w){1'b0}}, chan};

	always_comb begin
		state_nx = state;
		case (state)
			capture_pkg::idle: begin
				if (load) begin
					state_nx = capture_pkg::lane0;
				end
			end
			capture_pkg::lane0: begin
				if (step) begin
					state_nx = capture_pkg::lane1;
				end
			end
			capture_pkg::lane1: begin
				if (step) begin
					state_nx = capture_pkg::lane2;
				end
			end
			capture_pkg::lane2: begin
				if (step) begin
					state_nx = load ? capture_pkg::lane0 : capture_pkg::idle;
				end
			end
			default: begin
				state_nx = capture_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= capture_pkg::idle;
		end else begin
			state <= state_nx;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			sample_q <= buf_sample;
		end
	end

endmodule

// ==== logic/word_framer.sv ====
`timescale 1ns/1ps

module word_framer #(
	parameter int frame_samples = 4
) (
	input  logic                clk,
	input  logic                rst_n,

	chan_word_if.dst            words,

	output logic                out_valid,
	input  logic                out_ready,
	output capture_pkg::word_t  out_data,
	output capture_pkg::lane_t  out_lane,
	output logic                out_last
);

	localparam int frame_words = capture_pkg::chans * frame_samples;
	localparam int cnt_w = $clog2(frame_words);

	logic [cnt_w-1:0] cnt;	// words taken in the current frame
	logic take;
	logic frame_end;

	// slice empty or draining this cycle
	assign words.ready = !out_valid || out_ready;
	assign take = words.valid && words.ready;

	assign frame_end = (cnt == cnt_w'(frame_words - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (take) begin
			if (frame_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else if (words.ready) begin
			out_valid <= words.valid;
			out_last <= take && frame_end;	// always lands on a lane 2 word
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (take) begin
			out_data <= words.data;
			out_lane <= words.lane;
		end
	end

endmodule

// ==== logic/capture_top.sv ====
`timescale 1ns/1ps

module capture_top #(
	parameter int depth = 16,	// power of two
	parameter int frame_samples = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  capture_pkg::sample_t  in_sample,

	output logic                  out_valid,
	input  logic                  out_ready,
	output capture_pkg::word_t    out_data,
	output capture_pkg::lane_t    out_lane,
	output logic                  out_last,

	output logic                  overflow
);

	// buffer head towards splitter
	logic                 buf_valid;
	logic                 buf_ready;
	capture_pkg::sample_t buf_sample;

	chan_word_if words ();

	sample_buffer #(
		.depth (depth)
	) u_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_sample  (in_sample),
		.buf_valid  (buf_valid),
		.buf_ready  (buf_ready),
		.buf_sample (buf_sample),
		.overflow   (overflow)
	);

	sample_splitter u_splitter (
		.clk        (clk),
		.rst_n      (rst_n),
		.buf_valid  (buf_valid),
		.buf_ready  (buf_ready),
		.buf_sample (buf_sample),
		.words      (words.src)
	);

	word_framer #(
		.frame_samples (frame_samples)
	) u_framer (
		.clk       (clk),
		.rst_n     (rst_n),
		.words     (words.dst),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_lane  (out_lane),
		.out_last  (out_last)
	);

endmodule

// ==== include/capture_checks.svh ====
`ifndef CAPTURE_CHECKS_SVH
`define CAPTURE_CHECKS_SVH

int errors = 0;
int tests_run = 0;
int tests_failed = 0;

task automatic check_word(input string name, input capture_pkg::word_t got,
		input capture_pkg::word_t want);
	if (got !== want) begin
		errors++;
		$display("[FAIL] %0t %s expected %h got %h", $time, name, want, got);
	end
endtask

task automatic check_lane(input string name, input capture_pkg::lane_t got,
		input capture_pkg::lane_t want);
	if (got !== want) begin
		errors++;
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, want, got);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
	if (got !== want) begin
		errors++;
		$display("[FAIL] %0t %s expected %b got %b", $time, name, want, got);
	end
endtask

// counters kept by the testbench itself
task automatic check_count(input string name, input int got, input int want);
	if (got != want) begin
		errors++;
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, want, got);
	end
endtask

`endif

// ==== bench/capture_tb.sv ====
`timescale 1ns/1ps

module capture_tb;

	`include "capture_checks.svh"

	localparam int frame_words = 3 * 4;	// three lanes, four samples
	localparam int total_samples = 8 + 30 + 16 + 24 + 17;
	localparam int watchdog_ns = total_samples * 3 * 4 * 20 + 4000;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_ready;
	capture_pkg::sample_t in_sample;
	logic                 out_valid;
	logic                 out_ready;
	capture_pkg::word_t   out_data;
	capture_pkg::lane_t   out_lane;
	logic                 out_last;
	logic                 overflow;

	capture_pkg::word_t exp_data[$];
	capture_pkg::lane_t exp_lane[$];
	int out_count;	// words out since reset
	int last_count;
	int ready_pct;	// chance of out_ready per cycle
	string test_name;
	int errors_at_start;

	capture_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_sample (in_sample),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_lane  (out_lane),
		.out_last  (out_last),
		.overflow  (overflow)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		#2;
		out_ready = ($urandom_range(99) < ready_pct);
	end

	// lane i carries channel i, upper half zero
	function automatic capture_pkg::word_t expected_word(capture_pkg::sample_t s, int lane);
		capture_pkg::word_t w;
		w = '0;
		w[15:0] = s[lane*16 +: 16];
		return w;
	endfunction

	function automatic capture_pkg::sample_t random_sample();
		capture_pkg::sample_t s;
		s[31:0] = $urandom();
		s[47:32] = 16'($urandom());
		return s;
	endfunction

	// accepted samples
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_data.delete();
			exp_lane.delete();
		end else if (in_valid && in_ready) begin
			for (int i = 0; i < 3; i++) begin
				exp_data.push_back(expected_word(in_sample, i));
				exp_lane.push_back(capture_pkg::lane_t'(i));
			end
		end
	end

	// negedge sees the transfer due at the next edge
	always @(negedge clk) begin
		if (!rst_n) begin
			out_count = 0;
			last_count = 0;
		end else if (out_valid && out_ready) begin
			if (exp_data.size() == 0) begin
				errors++;
				$display("%0t: word %h came out with no sample pending", $time, out_data);
			end else begin
				check_word("out_data", out_data, exp_data.pop_front());
				check_lane("out_lane", out_lane, exp_lane.pop_front());
			end
			check_flag("out_last", out_last, (out_count % frame_words) == frame_words - 1);
			if (out_last) begin
				last_count++;
			end
			out_count++;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog: run did not finish within %0d ns", watchdog_ns);
		$display("Errors found");
		$finish;
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		in_valid = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// entered 2 ns after an edge, returns the same way
	task automatic send_sample(input capture_pkg::sample_t s, input int valid_pct);
		bit done;
		done = 1'b0;
		in_sample = s;
		while (!done) begin
			in_valid = ($urandom_range(99) < valid_pct);
			@(posedge clk);
			done = in_valid && in_ready;
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		ready_pct = 100;
		while (exp_data.size() != 0 && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		if (exp_data.size() != 0) begin
			errors++;
			$display("%0t: %0d expected words never came out", $time, exp_data.size());
		end
		repeat (8) @(posedge clk);	// catch stray words
		#2;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic ordered_conversion();
		start_test("ordered conversion");
		ready_pct = 100;
		for (int i = 0; i < 8; i++) begin
			send_sample(random_sample(), 100);
		end
		wait_drain(200);
		check_count("words out", out_count, 24);
		finish_test();
	endtask

	task automatic random_backpressure();
		start_test("random back-pressure");
		ready_pct = 50;
		for (int i = 0; i < 30; i++) begin
			send_sample(random_sample(), 60);
		end
		wait_drain(400);
		finish_test();
	endtask

	task automatic frame_marking();
		start_test("frame marking");
		ready_pct = 70;
		for (int i = 0; i < 16; i++) begin
			send_sample(random_sample(), 80);
		end
		wait_drain(300);
		check_count("frames", last_count, out_count / frame_words);
		finish_test();
	endtask

	task automatic overflow_drop();
		bit dropped;
		int n;
		start_test("overflow");
		dropped = 1'b0;
		n = 0;
		ready_pct = 0;
		apply_reset();	// earlier drops leave the flag set
		check_flag("overflow", overflow, 1'b0);
		repeat (2) @(posedge clk);
		#2;
		// fill until a sample meets a full buffer
		while (!dropped && n < 24) begin
			in_valid = 1'b1;
			in_sample = random_sample();
			@(posedge clk);
			dropped = !in_ready;
			n++;
			#2;
			if (!dropped) begin
				check_flag("overflow", overflow, 1'b0);
			end
		end
		in_valid = 1'b0;
		if (!dropped) begin
			errors++;
			$display("%0t: in_ready never went low with the output stalled", $time);
		end
		check_flag("overflow", overflow, 1'b1);
		wait_drain(300);
		check_flag("overflow", overflow, 1'b1);	// sticky
		finish_test();
	endtask

	task automatic reset_recovery();
		start_test("reset recovery");
		ready_pct = 50;
		for (int i = 0; i < 5; i++) begin
			send_sample(random_sample(), 100);
		end
		apply_reset();
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("out_last", out_last, 1'b0);
		check_flag("overflow", overflow, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
		ready_pct = 100;
		for (int i = 0; i < 12; i++) begin
			send_sample(random_sample(), 100);
		end
		wait_drain(200);
		check_count("words out", out_count, 36);
		check_count("frames", last_count, 3);
		finish_test();
	endtask

	initial begin
		void'($urandom(27076));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b0;
		ready_pct = 100;
		apply_reset();
		ordered_conversion();
		random_backpressure();
		frame_marking();
		overflow_drop();
		reset_recovery();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
logic/capture_pkg.sv
logic/chan_word_if.sv
logic/sample_buffer.sv
logic/sample_splitter.sv
logic/word_framer.sv
logic/capture_top.sv
bench/capture_tb.sv
